//--- verilog/simt_alu_cfg.svh
// Build-time sizes for the SIMT integer slice
// SIMT_LANE_BITS must equal clog2(SIMT_NUM_LANES), at most 6 for the shuffle fields
`ifndef SIMT_ALU_CFG_SVH
`define SIMT_ALU_CFG_SVH

`define SIMT_NUM_LANES 4    // Lanes per warp
`define SIMT_XLEN      32
`define SIMT_LANE_BITS 2
`define SIMT_NW_BITS   2    // Warp id width
`define SIMT_REG_BITS  5

`endif

//--- verilog/simt_alu_pkg.sv
// Types and op encodings shared by the integer slice
// An op code only has meaning together with its xtype
`include "simt_alu_cfg.svh"

package simt_alu_pkg;

    typedef logic [`SIMT_XLEN-1:0]      xlen_t;
    typedef xlen_t [`SIMT_NUM_LANES-1:0] lane_data_t;
    typedef logic [`SIMT_NUM_LANES-1:0] lane_mask_t;
    typedef logic [`SIMT_LANE_BITS-1:0] lane_idx_t;
    typedef logic [`SIMT_NW_BITS-1:0]   warp_id_t;
    typedef logic [`SIMT_REG_BITS-1:0]  reg_idx_t;
    typedef logic [19:0]                imm20_t;
    typedef logic [3:0]                 alu_op_t;

    typedef enum logic [1:0] {
        XT_ARITH  = 2'd0,
        XT_BRANCH = 2'd1,
        XT_OTHER  = 2'd2
    } xtype_t;

    typedef enum logic [1:0] {
        BUF_EMPTY = 2'd0,
        BUF_ONE   = 2'd1,
        BUF_TWO   = 2'd2
    } buf_state_t;

    // ARITH, bits 3..2 pick add, sub/compare, shift right, misc
    localparam alu_op_t ALU_ADD   = 4'b0000;
    localparam alu_op_t ALU_LUI   = 4'b0010;
    localparam alu_op_t ALU_AUIPC = 4'b0011;
    localparam alu_op_t ALU_SUB   = 4'b0100;
    localparam alu_op_t ALU_SLT   = 4'b0101;
    localparam alu_op_t ALU_SLTU  = 4'b0110;
    localparam alu_op_t ALU_SRL   = 4'b1000;
    localparam alu_op_t ALU_SRA   = 4'b1001;
    localparam alu_op_t ALU_AND   = 4'b1100;
    localparam alu_op_t ALU_OR    = 4'b1101;
    localparam alu_op_t ALU_XOR   = 4'b1110;
    localparam alu_op_t ALU_SLL   = 4'b1111;

    // BRANCH, bit 0 negates the condition
    localparam alu_op_t BR_BEQ  = 4'b0000;
    localparam alu_op_t BR_BNE  = 4'b0001;
    localparam alu_op_t BR_BLT  = 4'b0010;
    localparam alu_op_t BR_BGE  = 4'b0011;
    localparam alu_op_t BR_BLTU = 4'b0100;
    localparam alu_op_t BR_BGEU = 4'b0101;
    localparam alu_op_t BR_JAL  = 4'b0110;
    localparam alu_op_t BR_JALR = 4'b0111;

    // OTHER, bit 2 selects shuffle over vote
    localparam alu_op_t VOTE_ALL  = 4'b0000;
    localparam alu_op_t VOTE_ANY  = 4'b0001;
    localparam alu_op_t VOTE_UNI  = 4'b0010;
    localparam alu_op_t VOTE_BAL  = 4'b0011;
    localparam alu_op_t SHFL_UP   = 4'b0100;
    localparam alu_op_t SHFL_DOWN = 4'b0101;
    localparam alu_op_t SHFL_BFLY = 4'b0110;
    localparam alu_op_t SHFL_IDX  = 4'b0111;

endpackage

//--- verilog/alu_issue_decode.sv
// Input register stage; operands and immediates are formed before the flops
// LUI adds to zero; branches and JAL always add PC and imm x2, JALR adds rs1 and imm
`timescale 1ns/1ps
`include "simt_alu_cfg.svh"

module alu_issue_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  simt_alu_pkg::xtype_t     in_xtype,
    input  simt_alu_pkg::alu_op_t    in_op,
    input  logic                     in_use_pc,
    input  logic                     in_use_imm,
    input  simt_alu_pkg::imm20_t     in_imm20,
    input  simt_alu_pkg::xlen_t      in_pc,
    input  simt_alu_pkg::lane_mask_t in_tmask,
    input  simt_alu_pkg::lane_data_t in_rs1, in_rs2,
    input  simt_alu_pkg::warp_id_t   in_wid,
    input  simt_alu_pkg::reg_idx_t   in_rd,
    input  logic                     stage_ready,
    output logic                     dec_valid,
    output simt_alu_pkg::xtype_t     dec_xtype,
    output simt_alu_pkg::alu_op_t    dec_op,
    output simt_alu_pkg::xlen_t      dec_pc,
    output simt_alu_pkg::lane_mask_t dec_tmask,
    output simt_alu_pkg::warp_id_t   dec_wid,
    output simt_alu_pkg::reg_idx_t   dec_rd,
    output simt_alu_pkg::lane_data_t dec_rs1, dec_rs2,
    output simt_alu_pkg::lane_data_t dec_add_a, dec_add_b, dec_opnd2,
    output logic                     dec_signed
);
    import simt_alu_pkg::*;

    logic       is_br, is_rel, is_lui, is_upper, signed_op;
    xlen_t      imm_alu, imm_add;
    lane_data_t add_a, add_b, opnd2;

    assign is_br    = (in_xtype == XT_BRANCH);
    assign is_rel   = is_br && (in_op != BR_JALR);
    assign is_lui   = (in_xtype == XT_ARITH) && (in_op == ALU_LUI);
    assign is_upper = is_lui || ((in_xtype == XT_ARITH) && (in_op == ALU_AUIPC));
    assign imm_alu  = xlen_t'($signed(in_imm20));
    assign imm_add  = is_upper ? xlen_t'($signed({in_imm20, 12'd0}))
                    : is_rel ? xlen_t'($signed({in_imm20, 1'b0})) : imm_alu;

    assign signed_op = (in_xtype == XT_ARITH) ? (in_op == ALU_SLT || in_op == ALU_SRA)
                     : is_br && (in_op == BR_BLT || in_op == BR_BGE);

    assign add_a = is_lui ? '0 : ((in_use_pc || is_rel) ? {`SIMT_NUM_LANES{in_pc}} : in_rs1);
    assign add_b = (in_use_imm || is_br) ? {`SIMT_NUM_LANES{imm_add}} : in_rs2;
    assign opnd2 = (in_use_imm && !is_br) ? {`SIMT_NUM_LANES{imm_alu}} : in_rs2;   // Compare on rs2

    assign in_ready = !dec_valid || stage_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_xtype  <= in_xtype;
            dec_op     <= in_op;
            dec_pc     <= in_pc;
            dec_tmask  <= in_tmask;
            dec_wid    <= in_wid;
            dec_rd     <= in_rd;
            dec_rs1    <= in_rs1;
            dec_rs2    <= in_rs2;
            dec_add_a  <= add_a;
            dec_add_b  <= add_b;
            dec_opnd2  <= opnd2;
            dec_signed <= signed_op;
        end
    end

endmodule

//--- verilog/warp_crosslane.sv
// Vote and shuffle across the lanes of one warp, combinational
// Shuffle fields b, c and m sit at bits 0, 6 and 12 of each lane's rs2
`timescale 1ns/1ps
`include "simt_alu_cfg.svh"

module warp_crosslane (
    input  simt_alu_pkg::alu_op_t    op,
    input  simt_alu_pkg::lane_mask_t tmask,
    input  simt_alu_pkg::lane_data_t rs1,
    input  simt_alu_pkg::lane_data_t rs2,
    output simt_alu_pkg::lane_data_t xl_data
);
    import simt_alu_pkg::*;

    localparam int LB = `SIMT_LANE_BITS;

    lane_mask_t pred, vote_true, vote_false;
    xlen_t      vote_word;

    assign vote_true  = tmask & pred;
    assign vote_false = tmask & ~pred;

    always_comb begin
        case (op)
            VOTE_ALL: vote_word = xlen_t'(~|vote_false);
            VOTE_ANY: vote_word = xlen_t'(|vote_true);
            VOTE_UNI: vote_word = xlen_t'(~|vote_false || ~|vote_true);
            default:  vote_word = xlen_t'(vote_true);   // Ballot
        endcase
    end

    for (genvar i = 0; i < `SIMT_NUM_LANES; i++) begin : g_lane
        lane_idx_t   b, c, m, lo, hi, bfly, idx, src;
        logic [LB:0] up, down;

        assign b    = rs2[i][0 +: LB];
        assign c    = rs2[i][6 +: LB];
        assign m    = rs2[i][12 +: LB];
        assign lo   = lane_idx_t'(i) & m;
        assign hi   = lo | (c & ~m);
        assign up   = {1'b0, lane_idx_t'(i)} - {1'b0, b};   // MSB set when below lane 0
        assign down = {1'b0, lane_idx_t'(i)} + {1'b0, b};
        assign bfly = lane_idx_t'(i) ^ b;
        assign idx  = lo | (b & ~m);

        always_comb begin
            src = lane_idx_t'(i);
            case (op)
                SHFL_UP:   if (!up[LB] && (up[LB-1:0] >= lo))
                               src = up[LB-1:0];
                SHFL_DOWN: if (down <= {1'b0, hi})
                               src = down[LB-1:0];
                SHFL_BFLY: if (bfly <= hi)
                               src = bfly;
                default:   if (idx <= hi)
                               src = idx;
            endcase
        end

        assign pred[i]    = rs1[i][0];
        // Inactive source lane keeps own value
        assign xl_data[i] = op[2] ? (tmask[src] ? rs1[src] : rs1[i]) : vote_word;
    end

endmodule

//--- verilog/alu_lane_exec.sv
// Per-lane integer datapath and final result select, combinational
// Compare word: bit 0 less, bit 1 equal (branches only); shifts use 5 bits
`timescale 1ns/1ps
`include "simt_alu_cfg.svh"

module alu_lane_exec (
    input  simt_alu_pkg::xtype_t     xtype,
    input  simt_alu_pkg::alu_op_t    op,
    input  logic                     signed_op,
    input  simt_alu_pkg::lane_data_t rs1,
    input  simt_alu_pkg::lane_data_t add_a,
    input  simt_alu_pkg::lane_data_t add_b,
    input  simt_alu_pkg::lane_data_t opnd2,
    input  simt_alu_pkg::lane_mask_t tmask,
    input  simt_alu_pkg::lane_data_t rs2,
    output simt_alu_pkg::lane_data_t ex_data
);
    import simt_alu_pkg::*;

    localparam int XL = `SIMT_XLEN;

    lane_data_t xl_data;
    logic       is_br, is_jmp;

    assign is_br  = (xtype == XT_BRANCH);
    assign is_jmp = is_br && (op == BR_JAL || op == BR_JALR);

    warp_crosslane crosslane_i (
        .op      (op),
        .tmask   (tmask),
        .rs1     (rs1),
        .rs2     (rs2),
        .xl_data (xl_data)
    );

    for (genvar i = 0; i < `SIMT_NUM_LANES; i++) begin : g_lane
        xlen_t       add_res, shr_res, msc_res, cmp_word, res;
        logic [XL:0] sub_res;   // Top bit is the borrow
        logic [4:0]  shamt;

        assign shamt    = opnd2[i][4:0];
        assign add_res  = add_a[i] + add_b[i];
        assign sub_res  = {signed_op & rs1[i][XL-1], rs1[i]}
                        - {signed_op & opnd2[i][XL-1], opnd2[i]};
        assign shr_res  = xlen_t'($signed({signed_op & rs1[i][XL-1], rs1[i]}) >>> shamt);
        assign cmp_word = xlen_t'({is_br && (sub_res[XL-1:0] == '0), sub_res[XL]});

        always_comb begin
            case (op[1:0])
                2'b00:   msc_res = rs1[i] & opnd2[i];
                2'b01:   msc_res = rs1[i] | opnd2[i];
                2'b10:   msc_res = rs1[i] ^ opnd2[i];
                default: msc_res = rs1[i] << shamt;
            endcase
        end

        always_comb begin
            if (xtype == XT_OTHER) begin
                res = xl_data[i];
            end else if (is_br) begin
                res = is_jmp ? add_res : cmp_word;   // Jumps carry their target
            end else begin
                case (op[3:2])
                    2'b00:   res = add_res;   // ADD, LUI, AUIPC
                    2'b01:   res = (op == ALU_SUB) ? sub_res[XL-1:0] : cmp_word;
                    2'b10:   res = shr_res;
                    default: res = msc_res;
                endcase
            end
        end

        assign ex_data[i] = res;
    end

endmodule

//--- verilog/alu_result_buffer.sv
// Two-entry skid buffer, every output comes straight from flops
// ready_in drops only while both entries are full; order is kept
`timescale 1ns/1ps

module alu_result_buffer #(
    parameter int DATAW = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    import simt_alu_pkg::*;

    buf_state_t       state;
    logic [DATAW-1:0] skid;
    logic             push, pop;

    assign valid_out = (state != BUF_EMPTY);
    assign ready_in  = (state != BUF_TWO);
    assign push      = valid_in && ready_in;
    assign pop       = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= BUF_EMPTY;
        end else begin
            case (state)
                BUF_EMPTY: if (push)
                               state <= BUF_ONE;
                BUF_ONE:   if (push && !pop)
                               state <= BUF_TWO;
                           else if (pop && !push)
                               state <= BUF_EMPTY;
                default:   if (pop)
                               state <= BUF_ONE;
            endcase
        end
    end

    // Head entry drives data_out, second entry waits in skid
    always_ff @(posedge clk) begin
        if (state == BUF_TWO) begin
            if (pop) begin
                data_out <= skid;
            end
        end else if (push && (state == BUF_EMPTY || pop)) begin
            data_out <= data_in;
        end
        if (push && (state == BUF_ONE) && !pop) begin
            skid <= data_in;
        end
    end

endmodule

//--- verilog/branch_resolve.sv
// Resolves branches on the result leaving the buffer and forms writeback data
// Condition from the highest active lane, lane 0 when the mask is empty
`timescale 1ns/1ps
`include "simt_alu_cfg.svh"

module branch_resolve (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     buf_valid,
    input  logic                     res_ready,
    input  simt_alu_pkg::xtype_t     buf_xtype,
    input  simt_alu_pkg::alu_op_t    buf_op,
    input  simt_alu_pkg::xlen_t      buf_pc,
    input  simt_alu_pkg::lane_mask_t buf_tmask,
    input  simt_alu_pkg::warp_id_t   buf_wid,
    input  simt_alu_pkg::lane_data_t buf_data,
    input  simt_alu_pkg::xlen_t      buf_cbr_dest,
    output simt_alu_pkg::lane_data_t res_data,
    output logic                     br_valid,
    output simt_alu_pkg::warp_id_t   br_wid,
    output logic                     br_taken,
    output simt_alu_pkg::xlen_t      br_dest
);
    import simt_alu_pkg::*;

    lane_idx_t last;
    xlen_t     word, dest, pc_next;
    logic      is_br, is_jmp, is_less, is_neg, taken, br_fire;

    always_comb begin
        last = '0;
        for (int i = 0; i < `SIMT_NUM_LANES; i++) begin
            if (buf_tmask[i]) begin
                last = lane_idx_t'(i);
            end
        end
    end

    assign is_br   = (buf_xtype == XT_BRANCH);
    assign is_jmp  = is_br && (buf_op == BR_JAL || buf_op == BR_JALR);
    assign is_less = buf_op[2] | buf_op[1];   // BLT, BGE, BLTU, BGEU
    assign is_neg  = buf_op[0];
    assign word    = buf_data[last];
    assign taken   = ((is_less ? word[0] : word[1]) ^ is_neg) | is_jmp;
    assign dest    = !is_jmp ? buf_cbr_dest
                   : (buf_op == BR_JALR) ? (word & ~xlen_t'(1)) : word;
    assign br_fire = buf_valid && res_ready && is_br;

    // Link value for jumps
    assign pc_next  = buf_pc + xlen_t'(4);
    assign res_data = is_jmp ? {`SIMT_NUM_LANES{pc_next}} : buf_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            br_valid <= 1'b0;
        end else begin
            br_valid <= br_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (br_fire) begin
            br_wid   <= buf_wid;
            br_taken <= taken;
            br_dest  <= dest;
        end
    end

endmodule

//--- verilog/simt_alu_top.sv
// Integer slice of a SIMT core, decode register then two-entry result buffer
// Latency 2 cycles, up to three instructions in flight
`timescale 1ns/1ps

module simt_alu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  simt_alu_pkg::xtype_t     in_xtype,
    input  simt_alu_pkg::alu_op_t    in_op,
    input  logic                     in_use_pc,
    input  logic                     in_use_imm,
    input  simt_alu_pkg::imm20_t     in_imm20,
    input  simt_alu_pkg::xlen_t      in_pc,
    input  simt_alu_pkg::lane_mask_t in_tmask,
    input  simt_alu_pkg::lane_data_t in_rs1, in_rs2,
    input  simt_alu_pkg::warp_id_t   in_wid,
    input  simt_alu_pkg::reg_idx_t   in_rd,
    output logic                     res_valid,
    input  logic                     res_ready,
    output simt_alu_pkg::warp_id_t   res_wid,
    output simt_alu_pkg::reg_idx_t   res_rd,
    output simt_alu_pkg::lane_mask_t res_tmask,
    output simt_alu_pkg::xlen_t      res_pc,
    output simt_alu_pkg::lane_data_t res_data,
    output logic                     br_valid,
    output simt_alu_pkg::warp_id_t   br_wid,
    output logic                     br_taken,
    output simt_alu_pkg::xlen_t      br_dest
);
    import simt_alu_pkg::*;

    localparam int BUNDLE_W = $bits(warp_id_t) + $bits(reg_idx_t) + $bits(lane_mask_t)
                            + $bits(xtype_t) + $bits(alu_op_t) + 2 * $bits(xlen_t)
                            + $bits(lane_data_t);

    logic                dec_valid, dec_signed, stage_ready;
    xtype_t              dec_xtype;
    alu_op_t             dec_op, res_op;
    xlen_t               dec_pc, cbr_dest, res_cbr_dest;
    lane_mask_t          dec_tmask;
    warp_id_t            dec_wid;
    reg_idx_t            dec_rd;
    lane_data_t          dec_rs1, dec_rs2, dec_add_a, dec_add_b, dec_opnd2;
    lane_data_t          ex_data, res_ex_data;
    logic [1:0]          res_xtype;
    logic [BUNDLE_W-1:0] bundle_in, bundle_out;

    alu_issue_decode decode_i (.*);

    alu_lane_exec exec_i (
        .xtype (dec_xtype), .op (dec_op), .signed_op (dec_signed),
        .rs1 (dec_rs1), .add_a (dec_add_a), .add_b (dec_add_b), .opnd2 (dec_opnd2),
        .tmask (dec_tmask), .rs2 (dec_rs2), .ex_data (ex_data)
    );

    // Conditional branch target is lane 0's PC + imm sum
    assign cbr_dest   = dec_add_a[0] + dec_add_b[0];
    assign bundle_in  = {dec_wid, dec_rd, dec_tmask, dec_xtype, dec_op, dec_pc, cbr_dest,
                         ex_data};
    assign {res_wid, res_rd, res_tmask, res_xtype, res_op, res_pc, res_cbr_dest,
            res_ex_data} = bundle_out;

    alu_result_buffer #(
        .DATAW (BUNDLE_W)
    ) buffer_i (
        .clk (clk), .reset (reset),
        .valid_in (dec_valid), .ready_in (stage_ready), .data_in (bundle_in),
        .valid_out (res_valid), .ready_out (res_ready), .data_out (bundle_out)
    );

    branch_resolve resolve_i (
        .clk (clk), .reset (reset), .buf_valid (res_valid), .res_ready (res_ready),
        .buf_xtype (xtype_t'(res_xtype)), .buf_op (res_op), .buf_pc (res_pc),
        .buf_tmask (res_tmask), .buf_wid (res_wid), .buf_data (res_ex_data),
        .buf_cbr_dest (res_cbr_dest), .res_data (res_data),
        .br_valid (br_valid), .br_wid (br_wid), .br_taken (br_taken), .br_dest (br_dest)
    );

endmodule

//--- tb/simt_alu_assert.sv
// Handshake and branch strobe rules of the SIMT ALU top, bound into the DUT
`timescale 1ns/1ps

module simt_alu_assert (
    input logic                     clk,
    input logic                     reset,
    input logic                     res_valid,
    input logic                     res_ready,
    input logic [1:0]               res_xtype,
    input simt_alu_pkg::lane_data_t res_data,
    input simt_alu_pkg::xlen_t      res_pc,
    input simt_alu_pkg::warp_id_t   res_wid,
    input simt_alu_pkg::reg_idx_t   res_rd,
    input simt_alu_pkg::lane_mask_t res_tmask,
    input logic                     br_valid
);
    import simt_alu_pkg::*;

    a_res_hold: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_pc)
            && $stable(res_wid) && $stable(res_rd) && $stable(res_tmask))
        else $error("result changed while stalled");

    a_br_strobe: assert property (@(posedge clk) disable iff (reset)
        br_valid |-> $past(res_valid && res_ready && res_xtype == XT_BRANCH))
        else $error("br_valid without a branch result");

    a_reset_low: assert property (@(posedge clk) $fell(reset) |-> !res_valid && !br_valid)
        else $error("outputs valid right after reset");

endmodule

bind simt_alu_top simt_alu_assert assert_i (.*);

//--- tb/simt_alu_tb.sv
// Random self-checking testbench for simt_alu_top
// Ends when all tests drain or at the cycle limit
`timescale 1ns/1ps
`include "simt_alu_cfg.svh"

module simt_alu_tb;
    import simt_alu_pkg::*;

    localparam int NL      = `SIMT_NUM_LANES;
    localparam int N_TOTAL = 60 + 16 + 48 + 24 + 32 + 80;
    localparam int LIMIT   = 4 * N_TOTAL + 200;   // Timeout in cycles

    logic clk, reset, in_valid, in_ready, in_use_pc, in_use_imm, res_valid, res_ready;
    logic br_valid, br_taken;
    xtype_t in_xtype;
    alu_op_t in_op;
    imm20_t in_imm20;
    xlen_t in_pc, res_pc, br_dest;
    lane_mask_t in_tmask, res_tmask;
    lane_data_t in_rs1, in_rs2, res_data;
    warp_id_t in_wid, res_wid, br_wid;
    reg_idx_t in_rd, res_rd;

    lane_data_t q_data[$];
    xlen_t q_pc[$], q_dest[$];
    warp_id_t q_wid[$];
    reg_idx_t q_rd[$];
    lane_mask_t q_mask[$];
    logic q_br[$], q_taken[$];
    lane_data_t e_data, n_data;
    xlen_t e_dest, n_dest;
    warp_id_t e_wid;
    logic e_br, e_taken, n_taken, br_pend, bp_on;
    int seed, seed_bp, rb, errors, cycles, tests_ok, tests_bad;
    alu_op_t arith_ops[10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SRL, ALU_SRA,
                               ALU_AND, ALU_OR, ALU_XOR, ALU_SLL};

    simt_alu_top simt_alu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_data(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(string name, lane_mask_t got, lane_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_wid(string name, warp_id_t got, warp_id_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rd(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic lane_data_t ref_alu(xtype_t xt, alu_op_t op, logic upc, logic uimm,
            imm20_t imm, xlen_t pc, lane_mask_t tm, lane_data_t r1, lane_data_t r2,
            output logic taken, output xlen_t dest);
        lane_data_t d;
        lane_mask_t pred, vt, vf;
        xlen_t ia, iu, ib, a, b;
        logic less, eq;
        int last, lo, hi, bb, cc, mm, s;
        ia = {{12{imm[19]}}, imm};
        iu = {imm, 12'd0};
        ib = {{11{imm[19]}}, imm, 1'b0};
        last = 0;
        for (int l = 0; l < NL; l++) begin
            if (tm[l])
                last = l;
            pred[l] = r1[l][0];
        end
        vt = tm & pred;
        vf = tm & ~pred;
        for (int l = 0; l < NL; l++) begin
            a = r1[l];
            b = uimm ? ia : r2[l];
            if (xt == XT_ARITH) begin
                case (op)
                    ALU_ADD:   d[l] = (upc ? pc : a) + b;
                    ALU_LUI:   d[l] = iu;
                    ALU_AUIPC: d[l] = (upc ? pc : a) + iu;
                    ALU_SUB:   d[l] = a - b;
                    ALU_SLT:   d[l] = xlen_t'($signed(a) < $signed(b));
                    ALU_SLTU:  d[l] = xlen_t'(a < b);
                    ALU_SRL:   d[l] = a >> b[4:0];
                    ALU_SRA:   d[l] = xlen_t'($signed(a) >>> b[4:0]);
                    ALU_AND:   d[l] = a & b;
                    ALU_OR:    d[l] = a | b;
                    ALU_XOR:   d[l] = a ^ b;
                    default:   d[l] = a << b[4:0];
                endcase
            end else if (xt == XT_BRANCH) begin
                less = (op == BR_BLT || op == BR_BGE) ? ($signed(a) < $signed(r2[l]))
                                                      : (a < r2[l]);
                eq = (a == r2[l]);
                d[l] = xlen_t'({eq, less});
            end else if (!op[2]) begin
                case (op)
                    VOTE_ALL: d[l] = xlen_t'(vf == '0);
                    VOTE_ANY: d[l] = xlen_t'(vt != '0);
                    VOTE_UNI: d[l] = xlen_t'(vf == '0 || vt == '0);
                    default:  d[l] = xlen_t'(vt);
                endcase
            end else begin
                bb = r2[l][1:0];
                cc = r2[l][7:6];
                mm = r2[l][13:12];
                lo = l & mm;
                hi = lo | (cc & ~mm);
                s = l;
                case (op)
                    SHFL_UP:   if (l - bb >= lo) s = l - bb;
                    SHFL_DOWN: if (l + bb <= hi) s = l + bb;
                    SHFL_BFLY: if ((l ^ bb) <= hi) s = l ^ bb;
                    default:   if ((lo | (bb & ~mm)) <= hi) s = lo | (bb & ~mm);
                endcase
                d[l] = tm[s] ? r1[s] : r1[l];
            end
        end
        case (op)
            BR_BEQ:           taken = d[last][1];
            BR_BNE:           taken = !d[last][1];
            BR_BLT, BR_BLTU:  taken = d[last][0];
            BR_BGE, BR_BGEU:  taken = !d[last][0];
            default:          taken = 1'b1;
        endcase
        dest = (op == BR_JALR) ? ((r1[last] + ia) & ~xlen_t'(1)) : pc + ib;
        if (xt == XT_BRANCH && (op == BR_JAL || op == BR_JALR))
            d = {NL{pc + xlen_t'(4)}};
        return d;
    endfunction

    // Scoreboard sampled at the falling edge where everything has settled
    always @(negedge clk) begin
        if (br_pend) begin
            if (!br_valid) begin
                errors++;
                $display("Branch strobe missing one cycle after a branch result");
            end else begin
                check_wid("br_wid", br_wid, e_wid);
                check_flag("br_taken", br_taken, e_taken);
                check_pc("br_dest", br_dest, e_dest);
            end
        end else if (br_valid && !reset) begin
            errors++;
            $display("Branch strobe seen without a branch result before it");
        end
        br_pend = 1'b0;
        if (res_valid && res_ready && !reset) begin
            if (q_data.size() == 0) begin
                errors++;
                $display("Result came out with no instruction waiting for it");
            end else begin
                e_data = q_data.pop_front();
                for (int l = 0; l < NL; l++)
                    check_data($sformatf("res_data[%0d]", l), res_data[l], e_data[l]);
                e_wid = q_wid.pop_front();
                check_wid("res_wid", res_wid, e_wid);
                check_rd("res_rd", res_rd, q_rd.pop_front());
                check_mask("res_tmask", res_tmask, q_mask.pop_front());
                check_pc("res_pc", res_pc, q_pc.pop_front());
                e_br = q_br.pop_front();
                e_taken = q_taken.pop_front();
                e_dest = q_dest.pop_front();
                br_pend = e_br;
            end
        end
        if (in_valid && in_ready && !reset) begin
            n_data = ref_alu(in_xtype, in_op, in_use_pc, in_use_imm, in_imm20, in_pc,
                             in_tmask, in_rs1, in_rs2, n_taken, n_dest);
            q_data.push_back(n_data);
            q_taken.push_back(n_taken);
            q_dest.push_back(n_dest);
            q_br.push_back(in_xtype == XT_BRANCH);
            q_wid.push_back(in_wid);
            q_rd.push_back(in_rd);
            q_mask.push_back(in_tmask);
            q_pc.push_back(in_pc);
        end
    end

    always @(posedge clk) begin
        #1;
        rb = $random(seed_bp);
        res_ready = bp_on ? rb[0] : 1'b1;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles with results still missing", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic issue(xtype_t xt, alu_op_t op, logic upc, logic uimm, logic zmask);
        in_xtype = xt;
        in_op = op;
        in_use_pc = upc;
        in_use_imm = uimm;
        in_imm20 = imm20_t'($random(seed));
        in_pc = xlen_t'($random(seed)) & ~xlen_t'(3);
        in_tmask = zmask ? '0 : lane_mask_t'($random(seed));
        for (int l = 0; l < NL; l++) begin
            in_rs1[l] = $random(seed);
            in_rs2[l] = $random(seed);
            if (xt == XT_BRANCH && in_rs2[l][1:0] == 2'b00)
                in_rs2[l] = in_rs1[l];   // Hit the equal case often
        end
        in_wid = warp_id_t'($random(seed));
        in_rd = reg_idx_t'($random(seed));
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_test(string name, int kind, int n);
        int e0;
        int r;
        e0 = errors;
        bp_on = (kind == 5);
        for (int j = 0; j < n; j++) begin
            r = $random(seed) & 32'h7fff_ffff;
            case (kind)
                0, 5: issue(XT_ARITH, arith_ops[r % 10], 1'b0, r[4], 1'b0);
                1:    issue(XT_ARITH, r[0] ? ALU_AUIPC : ALU_LUI, 1'b1, 1'b1, 1'b0);
                2:    issue(XT_BRANCH, alu_op_t'(r % 8), 1'b0, 1'b0, 1'b0);
                3:    issue(XT_OTHER, alu_op_t'(j < 4 ? j : r % 4), 1'b0, 1'b0, j < 4);
                default: issue(XT_OTHER, alu_op_t'(4 + r % 4), 1'b0, 1'b0, 1'b0);
            endcase
        end
        bp_on = 1'b0;
        while (q_data.size() != 0 || br_pend)
            @(negedge clk);
        @(posedge clk);
        #1;
        if (errors == e0)
            tests_ok++;
        else
            tests_bad++;
        $display("%-12s %0d instructions, %0d errors", name, n, errors - e0);
    endtask

    initial begin
        seed = 87;
        seed_bp = 87;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        br_pend = 1'b0;
        bp_on = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        res_ready = 1'b1;
        in_xtype = XT_ARITH;
        in_op = '0;
        in_use_pc = 1'b0;
        in_use_imm = 1'b0;
        in_imm20 = '0;
        in_pc = '0;
        in_tmask = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_wid = '0;
        in_rd = '0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        run_test("arith", 0, 60);
        run_test("upper_imm", 1, 16);
        run_test("branch", 2, 48);
        run_test("vote", 3, 24);
        run_test("shuffle", 4, 32);
        run_test("backpress", 5, 80);
        $display("%0d tests passed, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/simt_alu_pkg.sv
verilog/alu_issue_decode.sv
verilog/warp_crosslane.sv
verilog/alu_lane_exec.sv
verilog/alu_result_buffer.sv
verilog/branch_resolve.sv
verilog/simt_alu_top.sv
tb/simt_alu_assert.sv
tb/simt_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMT ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module simt_alu_tb -o simt_alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simt_alu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
